//--- source/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and address width
`define CPU_DATA_WIDTH 32

// register number width, 32 registers
`define CPU_REG_ADDR_WIDTH 5

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

//--- source/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_WIDTH-1:0] word_t;
    typedef logic [`CPU_REG_ADDR_WIDTH-1:0] regAddr_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui  // immediate into upper half
    } aluOp_e;

    typedef enum logic [1:0] {
        fwdReg,
        fwdMem,
        fwdWb
    } fwdSel_e;

    typedef struct packed {
        word_t instr;
        word_t pc;
        logic  valid;
    } fetchToDecode_t;

    typedef struct packed {
        word_t    pc;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;  // destination after rd/rt choice
        word_t    rsData;
        word_t    rtData;
        word_t    imm;
        aluOp_e   aluOp;
        logic     useImm;
        logic     regWrite;
        logic     load;
        logic     store;
        logic     branchEq;
        logic     branchNe;
        logic     jump;
        word_t    jumpTarget;
        logic     valid;
    } decodeToExecute_t;

    typedef struct packed {
        word_t    pc;
        word_t    aluResult;
        word_t    storeData;
        regAddr_t rd;
        logic     regWrite;
        logic     load;
        logic     store;
        logic     valid;
    } executeToMem_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        regAddr_t rd;
        word_t    data;
    } wbTrace_t;

endpackage

//--- source/registerFile.sv
module registerFile (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              we_i,
    input  cpu_pkg::regAddr_t wAddr_i,
    input  cpu_pkg::regAddr_t rsAddr_i,
    input  cpu_pkg::regAddr_t rtAddr_i,
    input  cpu_pkg::word_t    wData_i,
    output cpu_pkg::word_t    rsData_o,
    output cpu_pkg::word_t    rtData_o
);

    cpu_pkg::word_t regs [32];
    logic           wrLive;

    assign wrLive = we_i && (wAddr_i != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs[0] <= '0;
        end else if (wrLive) begin
            regs[wAddr_i] <= wData_i;
        end
    end

    // same-cycle writeback bypass
    assign rsData_o = (wrLive && wAddr_i == rsAddr_i) ? wData_i : regs[rsAddr_i];
    assign rtData_o = (wrLive && wAddr_i == rtAddr_i) ? wData_i : regs[rtAddr_i];

    // both read ports see zero for register zero, bypass included
    zeroReg: assert property (@(posedge clk) disable iff (reset_i)
        (rsAddr_i != '0 || rsData_o == '0) && (rtAddr_i != '0 || rtData_o == '0));

endmodule

//--- source/fetchUnit.sv
`include "cpu_config.svh"

module fetchUnit (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    hold_i,
    input  logic                    flush_i,
    input  logic                    redirect_i,
    input  cpu_pkg::word_t          redirectPc_i,
    input  cpu_pkg::word_t          instr_i,
    output cpu_pkg::word_t          instAddr_o,
    output logic                    instEn_o,
    output cpu_pkg::fetchToDecode_t fetched_o
);

    cpu_pkg::word_t pc;

    assign instAddr_o = pc;
    assign instEn_o   = 1'b1;  // always fetching, stalls come from memory

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc              <= `CPU_RESET_PC;
            fetched_o.valid <= 1'b0;
        end else if (!hold_i) begin
            pc              <= redirect_i ? redirectPc_i : pc + 32'd4;
            fetched_o.instr <= instr_i;
            fetched_o.pc    <= pc;
            fetched_o.valid <= !flush_i;  // squashed by a taken branch
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (reset_i) pc[1:0] == 2'b00);

endmodule

//--- source/decodeUnit.sv
module decodeUnit (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      hold_i,
    input  logic                      flush_i,
    input  cpu_pkg::fetchToDecode_t   fetched_i,
    input  cpu_pkg::word_t            rsData_i,
    input  cpu_pkg::word_t            rtData_i,
    output cpu_pkg::regAddr_t         rsAddr_o,
    output cpu_pkg::regAddr_t         rtAddr_o,
    output cpu_pkg::decodeToExecute_t decoded_o
);

    cpu_pkg::decodeToExecute_t next;
    cpu_pkg::word_t            instr, pcPlus4;
    logic                      legal;

    assign instr    = fetched_i.instr;
    assign pcPlus4  = fetched_i.pc + 32'd4;
    assign rsAddr_o = instr[25:21];
    assign rtAddr_o = instr[20:16];

    always_comb begin
        next            = '0;
        legal           = 1'b1;
        next.pc         = fetched_i.pc;
        next.rs         = instr[25:21];
        next.rt         = instr[20:16];
        next.rsData     = rsData_i;
        next.rtData     = rtData_i;
        next.imm        = {{16{instr[15]}}, instr[15:0]};  // sign extended by default
        next.jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};
        next.aluOp      = cpu_pkg::aluAdd;
        next.valid      = 1'b1;
        case (instr[31:26])
            6'h00: begin
                next.rd       = instr[15:11];
                next.regWrite = 1'b1;
                case (instr[5:0])
                    6'h21: next.aluOp = cpu_pkg::aluAdd;
                    6'h23: next.aluOp = cpu_pkg::aluSub;
                    6'h24: next.aluOp = cpu_pkg::aluAnd;
                    6'h25: next.aluOp = cpu_pkg::aluOr;
                    6'h2a: next.aluOp = cpu_pkg::aluSlt;
                    default: legal = 1'b0;
                endcase
            end
            6'h09: begin  // addiu
                next.rd       = instr[20:16];
                next.regWrite = 1'b1;
                next.useImm   = 1'b1;
            end
            6'h0d, 6'h0f: begin  // ori, lui
                next.rd       = instr[20:16];
                next.regWrite = 1'b1;
                next.useImm   = 1'b1;
                next.imm      = {16'h0000, instr[15:0]};
                next.aluOp    = instr[27] ? cpu_pkg::aluLui : cpu_pkg::aluOr;
            end
            6'h23: begin  // lw
                next.rd       = instr[20:16];
                next.regWrite = 1'b1;
                next.useImm   = 1'b1;
                next.load     = 1'b1;
            end
            6'h2b: begin  // sw
                next.useImm = 1'b1;
                next.store  = 1'b1;
            end
            6'h04: next.branchEq = 1'b1;
            6'h05: next.branchNe = 1'b1;
            6'h02: next.jump = 1'b1;
            default: legal = 1'b0;
        endcase
        if (!(fetched_i.valid && legal)) begin
            next = '0;  // bubble
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            decoded_o <= '0;
        end else if (!hold_i) begin
            decoded_o <= flush_i ? '0 : next;
        end
    end

endmodule

//--- source/executeUnit.sv
module executeUnit (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      hold_i,
    input  logic                      flush_i,
    input  cpu_pkg::decodeToExecute_t decoded_i,
    input  cpu_pkg::fwdSel_e          fwdA_i,
    input  cpu_pkg::fwdSel_e          fwdB_i,
    input  cpu_pkg::word_t            memResult_i,
    input  cpu_pkg::word_t            wbResult_i,
    output logic                      redirect_o,
    output cpu_pkg::word_t            redirectPc_o,
    output cpu_pkg::executeToMem_t    executed_o
);

    cpu_pkg::word_t         rsVal, rtVal, opB, aluResult, branchTarget;
    cpu_pkg::executeToMem_t next;
    logic                   equal, taken;

    always_comb begin
        case (fwdA_i)
            cpu_pkg::fwdMem: rsVal = memResult_i;
            cpu_pkg::fwdWb:  rsVal = wbResult_i;
            default:         rsVal = decoded_i.rsData;
        endcase
        case (fwdB_i)
            cpu_pkg::fwdMem: rtVal = memResult_i;
            cpu_pkg::fwdWb:  rtVal = wbResult_i;
            default:         rtVal = decoded_i.rtData;
        endcase
    end

    assign opB = decoded_i.useImm ? decoded_i.imm : rtVal;

    always_comb begin
        case (decoded_i.aluOp)
            cpu_pkg::aluSub: aluResult = rsVal - opB;
            cpu_pkg::aluAnd: aluResult = rsVal & opB;
            cpu_pkg::aluOr:  aluResult = rsVal | opB;
            cpu_pkg::aluSlt: aluResult = {31'b0, $signed(rsVal) < $signed(opB)};
            cpu_pkg::aluLui: aluResult = {opB[15:0], 16'h0000};
            default:         aluResult = rsVal + opB;
        endcase
    end

    assign equal        = (rsVal == rtVal);
    assign taken        = decoded_i.jump || (decoded_i.branchEq && equal)
                          || (decoded_i.branchNe && !equal);
    assign redirect_o   = decoded_i.valid && taken;
    assign branchTarget = decoded_i.pc + 32'd4 + {decoded_i.imm[29:0], 2'b00};
    assign redirectPc_o = decoded_i.jump ? decoded_i.jumpTarget : branchTarget;

    always_comb begin
        next           = '0;
        next.pc        = decoded_i.pc;
        next.aluResult = aluResult;
        next.storeData = rtVal;  // forwarded store data
        next.rd        = decoded_i.rd;
        next.regWrite  = decoded_i.regWrite;
        next.load      = decoded_i.load;
        next.store     = decoded_i.store;
        next.valid     = decoded_i.valid;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            executed_o <= '0;
        end else if (!hold_i) begin
            executed_o <= flush_i ? '0 : next;
        end
    end

endmodule

//--- source/memAccessUnit.sv
module memAccessUnit (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   hold_i,
    input  cpu_pkg::executeToMem_t executed_i,
    input  cpu_pkg::word_t         dataRdata_i,
    output logic                   dataEn_o,
    output logic                   dataWe_o,
    output cpu_pkg::word_t         dataAddr_o,
    output cpu_pkg::word_t         dataWdata_o,
    output cpu_pkg::word_t         memResult_o,
    output logic                   wbWe_o,
    output cpu_pkg::regAddr_t      wbAddr_o,
    output cpu_pkg::word_t         wbData_o,
    output cpu_pkg::wbTrace_t      wbTrace_o
);

    assign dataEn_o    = executed_i.valid && (executed_i.load || executed_i.store);
    assign dataWe_o    = executed_i.valid && executed_i.store;
    assign dataAddr_o  = executed_i.aluResult;
    assign dataWdata_o = executed_i.storeData;
    assign memResult_o = executed_i.load ? dataRdata_i : executed_i.aluResult;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wbWe_o          <= 1'b0;
            wbTrace_o.valid <= 1'b0;
        end else if (hold_i) begin
            wbTrace_o.valid <= 1'b0;  // report each retirement once
        end else begin
            wbWe_o          <= executed_i.valid && executed_i.regWrite;
            wbTrace_o.valid <= executed_i.valid && executed_i.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            wbAddr_o       <= executed_i.rd;
            wbData_o       <= memResult_o;
            wbTrace_o.pc   <= executed_i.pc;
            wbTrace_o.rd   <= executed_i.rd;
            wbTrace_o.data <= (executed_i.rd == '0) ? '0 : memResult_o;
        end
    end

    dataAligned: assert property (@(posedge clk) disable iff (reset_i)
        dataEn_o |-> dataAddr_o[1:0] == 2'b00);

endmodule

//--- source/hazardUnit.sv
module hazardUnit (
    input  logic              iStall_i,
    input  logic              dStall_i,
    input  logic              redirect_i,
    input  cpu_pkg::regAddr_t decRs_i,
    input  cpu_pkg::regAddr_t decRt_i,
    input  cpu_pkg::regAddr_t exRs_i,
    input  cpu_pkg::regAddr_t exRt_i,
    input  cpu_pkg::regAddr_t memRd_i,
    input  cpu_pkg::regAddr_t wbRd_i,
    input  logic              memRegWrite_i,
    input  logic              memLoad_i,
    input  logic              wbRegWrite_i,
    input  logic              exLoad_i,
    input  cpu_pkg::regAddr_t exRd_i,
    output logic              holdF_o,
    output logic              holdD_o,
    output logic              holdE_o,
    output logic              holdM_o,
    output logic              flushD_o,
    output logic              flushE_o,
    output cpu_pkg::fwdSel_e  fwdA_o,
    output cpu_pkg::fwdSel_e  fwdB_o
);

    logic freeze, loadUse;

    function automatic cpu_pkg::fwdSel_e pickSource(input cpu_pkg::regAddr_t src);
        if (memRegWrite_i && !memLoad_i && memRd_i != '0 && memRd_i == src) begin
            return cpu_pkg::fwdMem;  // youngest producer wins
        end else if (wbRegWrite_i && wbRd_i != '0 && wbRd_i == src) begin
            return cpu_pkg::fwdWb;
        end
        return cpu_pkg::fwdReg;
    endfunction

    always_comb begin
        fwdA_o = pickSource(exRs_i);
        fwdB_o = pickSource(exRt_i);
    end

    assign freeze  = iStall_i || dStall_i;
    assign loadUse = exLoad_i && exRd_i != '0 && (exRd_i == decRs_i || exRd_i == decRt_i);

    assign holdF_o  = freeze || loadUse;
    assign holdD_o  = freeze;
    assign holdE_o  = freeze;
    assign holdM_o  = freeze;
    assign flushD_o = redirect_i && !freeze;
    assign flushE_o = (redirect_i || loadUse) && !freeze;

    // a load in execute never redirects
    always_comb begin
        noFlushWhileHeld: assert #0 (freeze || !(flushD_o && holdF_o));
    end

endmodule

//--- source/cpuDatapath.sv
module cpuDatapath (
    input  logic             clk,
    input  logic             reset_i,
    input  cpu_pkg::word_t   instr_i,
    input  logic             iStall_i,
    output cpu_pkg::word_t   instAddr_o,
    output logic             instEn_o,
    input  cpu_pkg::word_t   dataRdata_i,
    input  logic             dStall_i,
    output logic             dataEn_o,
    output logic             dataWe_o,
    output cpu_pkg::word_t   dataAddr_o,
    output cpu_pkg::word_t   dataWdata_o,
    output cpu_pkg::wbTrace_t wbTrace_o
);

    cpu_pkg::fetchToDecode_t   fetched;
    cpu_pkg::decodeToExecute_t decoded;
    cpu_pkg::executeToMem_t    executed;
    cpu_pkg::regAddr_t         rsAddr, rtAddr, wbAddr;
    cpu_pkg::word_t            rsData, rtData, wbData, memResult, redirectPc;
    cpu_pkg::fwdSel_e          fwdA, fwdB;
    logic                      wbWe, redirect;
    logic                      holdF, holdD, holdE, holdM, flushD, flushE;

    fetchUnit fetch (
        .clk(clk), .reset_i(reset_i), .hold_i(holdF), .flush_i(flushD),
        .redirect_i(redirect), .redirectPc_i(redirectPc), .instr_i(instr_i),
        .instAddr_o(instAddr_o), .instEn_o(instEn_o), .fetched_o(fetched)
    );

    decodeUnit decode (
        .clk(clk), .reset_i(reset_i), .hold_i(holdD), .flush_i(flushE),
        .fetched_i(fetched), .rsData_i(rsData), .rtData_i(rtData),
        .rsAddr_o(rsAddr), .rtAddr_o(rtAddr), .decoded_o(decoded)
    );

    registerFile regs (
        .clk(clk), .reset_i(reset_i), .we_i(wbWe), .wAddr_i(wbAddr),
        .rsAddr_i(rsAddr), .rtAddr_i(rtAddr), .wData_i(wbData),
        .rsData_o(rsData), .rtData_o(rtData)
    );

    executeUnit execute (
        .clk(clk), .reset_i(reset_i), .hold_i(holdE), .flush_i(1'b0),
        .decoded_i(decoded), .fwdA_i(fwdA), .fwdB_i(fwdB),
        .memResult_i(memResult), .wbResult_i(wbData),
        .redirect_o(redirect), .redirectPc_o(redirectPc), .executed_o(executed)
    );

    memAccessUnit memAccess (
        .clk(clk), .reset_i(reset_i), .hold_i(holdM), .executed_i(executed),
        .dataRdata_i(dataRdata_i), .dataEn_o(dataEn_o), .dataWe_o(dataWe_o),
        .dataAddr_o(dataAddr_o), .dataWdata_o(dataWdata_o), .memResult_o(memResult),
        .wbWe_o(wbWe), .wbAddr_o(wbAddr), .wbData_o(wbData), .wbTrace_o(wbTrace_o)
    );

    hazardUnit hazard (
        .iStall_i(iStall_i), .dStall_i(dStall_i), .redirect_i(redirect),
        .decRs_i(rsAddr), .decRt_i(rtAddr), .exRs_i(decoded.rs), .exRt_i(decoded.rt),
        .memRd_i(executed.rd), .wbRd_i(wbAddr),
        .memRegWrite_i(executed.regWrite), .memLoad_i(executed.load),
        .wbRegWrite_i(wbWe), .exLoad_i(decoded.load), .exRd_i(decoded.rd),
        .holdF_o(holdF), .holdD_o(holdD), .holdE_o(holdE), .holdM_o(holdM),
        .flushD_o(flushD), .flushE_o(flushE), .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

endmodule

//--- dv/cpuTb.sv
module cpuTb;

    typedef struct packed {
        cpu_pkg::word_t    instr;
        logic              retires;  // appears on the trace
        cpu_pkg::regAddr_t rd;
        cpu_pkg::word_t    data;
    } progRow_t;

    localparam int MemWords     = 64;
    localparam int TraceTimeout = 200;

    logic              clk;
    logic              reset_i;
    logic              iStall_i, dStall_i;
    cpu_pkg::word_t    instr_i, dataRdata_i;
    cpu_pkg::word_t    instAddr_o, dataAddr_o, dataWdata_o;
    logic              instEn_o, dataEn_o, dataWe_o;
    cpu_pkg::wbTrace_t wbTrace_o;

    progRow_t          prog [MemWords];
    cpu_pkg::word_t    ram [MemWords];
    int                rowCount;
    int                errors;
    logic              finalStoreSeen;

    cpuDatapath dut (
        .clk(clk), .reset_i(reset_i), .instr_i(instr_i), .iStall_i(iStall_i),
        .instAddr_o(instAddr_o), .instEn_o(instEn_o), .dataRdata_i(dataRdata_i),
        .dStall_i(dStall_i), .dataEn_o(dataEn_o), .dataWe_o(dataWe_o),
        .dataAddr_o(dataAddr_o), .dataWdata_o(dataWdata_o), .wbTrace_o(wbTrace_o)
    );

    function automatic cpu_pkg::word_t rType(input int rs, input int rt, input int rd,
                                             input logic [5:0] funct);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'h00, funct};
    endfunction

    function automatic cpu_pkg::word_t iType(input logic [5:0] op, input int rs, input int rt,
                                             input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic cpu_pkg::word_t jType(input cpu_pkg::word_t target);
        return {6'h02, target[27:2]};
    endfunction

    function automatic cpu_pkg::word_t fillWord(input int index);
        return 32'hd00d_0000 ^ (index << 2);  // differs for every word address
    endfunction

    task automatic addRow(input cpu_pkg::word_t instr, input logic retires, input int rd,
                          input cpu_pkg::word_t data);
        prog[rowCount[5:0]] = {instr, retires, rd[4:0], data};
        rowCount++;
    endtask

    task automatic checkValue(input string name, input cpu_pkg::word_t actual,
                              input cpu_pkg::word_t expected);
        if (actual !== expected) begin
            errors++;
            $display("error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    // program and expected trace, one row per word from pc 0
    task automatic loadProgram();
        for (int i = 0; i < MemWords; i++) begin
            prog[i[5:0]] = '0;
        end
        rowCount = 0;
        addRow(iType(6'h09, 0, 1, 16'h0005), 1'b1, 1, 32'h0000_0005);   // addiu
        addRow(iType(6'h09, 1, 2, 16'h0003), 1'b1, 2, 32'h0000_0008);   // from mem
        addRow(rType(1, 2, 3, 6'h21), 1'b1, 3, 32'h0000_000d);          // wb and mem
        addRow(rType(3, 1, 4, 6'h23), 1'b1, 4, 32'h0000_0008);          // subu
        addRow(iType(6'h0f, 0, 5, 16'h1234), 1'b1, 5, 32'h1234_0000);   // lui
        addRow(iType(6'h0d, 5, 5, 16'h5678), 1'b1, 5, 32'h1234_5678);   // ori
        addRow(rType(5, 3, 6, 6'h24), 1'b1, 6, 32'h0000_0008);          // and
        addRow(rType(5, 1, 7, 6'h25), 1'b1, 7, 32'h1234_567d);          // or
        addRow(rType(4, 3, 8, 6'h2a), 1'b1, 8, 32'h0000_0001);          // slt true
        addRow(iType(6'h09, 0, 9, 16'hffff), 1'b1, 9, 32'hffff_ffff);   // sign extended
        addRow(rType(9, 0, 10, 6'h2a), 1'b1, 10, 32'h0000_0001);        // -1 < 0
        addRow(rType(1, 9, 11, 6'h2a), 1'b1, 11, 32'h0000_0000);        // 5 < -1 false
        addRow(iType(6'h2b, 0, 5, 16'h0010), 1'b0, 0, 32'h0);           // sw
        addRow(iType(6'h23, 0, 12, 16'h0010), 1'b1, 12, 32'h1234_5678); // lw
        addRow(rType(12, 1, 13, 6'h21), 1'b1, 13, 32'h1234_567d);       // load use
        addRow(iType(6'h09, 0, 0, 16'h0007), 1'b1, 0, 32'h0000_0000);   // write r0
        addRow(rType(0, 1, 14, 6'h21), 1'b1, 14, 32'h0000_0005);        // reads r0
        addRow(iType(6'h04, 1, 14, 16'h0002), 1'b0, 0, 32'h0);          // beq taken
        addRow(iType(6'h09, 0, 15, 16'h0011), 1'b0, 0, 32'h0);
        addRow(iType(6'h09, 0, 15, 16'h0022), 1'b0, 0, 32'h0);
        addRow(iType(6'h05, 1, 2, 16'h0002), 1'b0, 0, 32'h0);           // bne taken
        addRow(iType(6'h09, 0, 15, 16'h0033), 1'b0, 0, 32'h0);
        addRow(iType(6'h09, 0, 15, 16'h0044), 1'b0, 0, 32'h0);
        addRow(iType(6'h04, 1, 2, 16'h0002), 1'b0, 0, 32'h0);           // beq not taken
        addRow(iType(6'h09, 0, 16, 16'h0030), 1'b1, 16, 32'h0000_0030);
        addRow(iType(6'h05, 1, 14, 16'h0002), 1'b0, 0, 32'h0);          // bne not taken
        addRow(iType(6'h09, 16, 17, 16'h0001), 1'b1, 17, 32'h0000_0031);
        addRow(jType(32'h0000_0078), 1'b0, 0, 32'h0);                   // j
        addRow(iType(6'h09, 0, 18, 16'h0055), 1'b0, 0, 32'h0);
        addRow(iType(6'h09, 0, 18, 16'h0066), 1'b0, 0, 32'h0);
        addRow(rType(17, 16, 19, 6'h21), 1'b1, 19, 32'h0000_0061);
        addRow(iType(6'h2b, 0, 19, 16'h0014), 1'b0, 0, 32'h0);          // final sw
        addRow(jType(32'h0000_0080), 1'b0, 0, 32'h0);                   // parks here
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memories answer in the same cycle, inputs settle 2 units after the edge
    initial begin
        logic inReset;
        void'($urandom(25752));
        forever begin
            @(posedge clk);
            inReset = reset_i;
            if (!inReset && dataEn_o && dataWe_o && !dStall_i) begin
                ram[dataAddr_o[7:2]] = dataWdata_o;
                if (dataAddr_o == 32'h0000_0014) begin
                    finalStoreSeen = 1'b1;
                end
            end
            #2;
            iStall_i    = !inReset && (($urandom % 4) == 0);
            dStall_i    = !inReset && (($urandom % 5) == 0);
            instr_i     = (!instEn_o || iStall_i || instAddr_o[31:8] != '0)
                          ? 32'hffff_ffff : prog[instAddr_o[7:2]].instr;
            dataRdata_i = dStall_i ? 32'hbad0_bad0 : ram[dataAddr_o[7:2]];  // junk while stalled
        end
    end

    initial begin
        int waited;
        errors         = 0;
        finalStoreSeen = 1'b0;
        reset_i        = 1'b1;
        iStall_i       = 1'b0;
        dStall_i       = 1'b0;
        instr_i        = '0;
        dataRdata_i    = '0;
        loadProgram();
        for (int i = 0; i < MemWords; i++) begin
            ram[i[5:0]] = fillWord(i);
        end
        repeat (4) @(posedge clk);
        #2 reset_i = 1'b0;

        // state left by reset
        checkValue("instEn_o", {31'b0, instEn_o}, 32'h0000_0001);
        checkValue("instAddr_o", instAddr_o, 32'h0000_0000);
        checkValue("dataEn_o", {31'b0, dataEn_o}, 32'h0000_0000);
        checkValue("dataWe_o", {31'b0, dataWe_o}, 32'h0000_0000);
        checkValue("wbTrace_o.valid", {31'b0, wbTrace_o.valid}, 32'h0000_0000);

        for (int i = 0; i < rowCount; i++) begin
            if (prog[i[5:0]].retires) begin
                waited = 0;
                @(negedge clk);
                while (!wbTrace_o.valid && waited < TraceTimeout) begin
                    @(negedge clk);
                    waited++;
                end
                if (!wbTrace_o.valid) begin
                    errors++;
                    $display("timeout: no register write retired for pc %h", i * 4);
                    break;
                end
                checkValue("wbTrace_o.pc", wbTrace_o.pc, cpu_pkg::word_t'(i * 4));
                checkValue("wbTrace_o.rd", {27'b0, wbTrace_o.rd}, {27'b0, prog[i[5:0]].rd});
                checkValue("wbTrace_o.data", wbTrace_o.data, prog[i[5:0]].data);
            end
        end

        waited = 0;
        while (!finalStoreSeen && waited < TraceTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (!finalStoreSeen) begin
            errors++;
            $display("timeout: the final store never reached the data RAM");
        end
        checkValue("ram[4]", ram[4], 32'h1234_5678);
        checkValue("ram[5]", ram[5], 32'h0000_0061);
        checkValue("ram[6]", ram[6], fillWord(6));  // untouched neighbour

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+source
source/cpu_pkg.sv
source/registerFile.sv
source/fetchUnit.sv
source/decodeUnit.sv
source/executeUnit.sv
source/memAccessUnit.sv
source/hazardUnit.sv
source/cpuDatapath.sv
dv/cpuTb.sv

//--- Makefile
# Verilator build and run for the five-stage CPU testbench

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module cpuTb

sim:
	verilator --binary --timing --assert -f project.f --top-module cpuTb -Mdir obj_dir
	./obj_dir/VcpuTb | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
